// File: Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP = cpuControlTb
FILELIST = cpuControl.f
BUILDDIR = obj_dir
PASS = sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: build
	@out="$$(./$(BUILDDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR)

// File: cpuControl.f
rtl/controlPkg.sv
rtl/irqSync.sv
rtl/flagCondition.sv
rtl/cycleSequencer.sv
rtl/controlDecode.sv
rtl/cpuControl.sv
testbench/cpuControl_checker.sv
testbench/cpuControlTb.sv

// File: rtl/controlDecode.sv
// Control strobe decoder for fetch, execute and interrupt entry subcycles
`timescale 1ns/10ps

module controlDecode import controlPkg::*; (
	input majorState_t State,
	input subCycle_t SubCycle,
	input instrByte_t Instr,
	input logic BranchTaken,
	output logic ALE,
	output logic AluEn,
	output logic AluWe,
	output aluOr_t AluOr,
	output logic Enb,
	output immSel_t ImmSel,
	output logic IrWe,
	output logic LrEn,
	output lrSel_t LrSel,
	output logic LrWe,
	output logic MemEn,
	output logic nME,
	output logic nOE,
	output logic nWE,
	output op1Sel_t Op1Sel,
	output op2Sel_t Op2Sel,
	output logic PcEn,
	output pcSel_t PcSel,
	output logic PcWe,
	output logic RegWe,
	output rs1Sel_t Rs1Sel,
	output rwSel_t RwSel,
	output wdSel_t WdSel,
	output logic StatusWe,
	output logic IntClear,
	output logic IntEnable,
	output logic IntDisable
);

	opcode_t opcode;

	assign opcode = Instr.branch.opcode;

	always_comb begin
		ALE = 1'b0;
		AluEn = 1'b0;
		AluWe = 1'b0;
		AluOr = nOR;
		Enb = 1'b0;
		ImmSel = ImmLong;
		IrWe = 1'b0;
		LrEn = 1'b0;
		LrSel = LrSys;
		LrWe = 1'b0;
		MemEn = 1'b0;
		nME = 1'b1;
		nOE = 1'b1;
		nWE = 1'b1;
		Op1Sel = Op1Rd1;
		Op2Sel = Op2Imm;
		PcEn = 1'b0;
		PcSel = Pc1;
		PcWe = 1'b0;
		RegWe = 1'b0;
		Rs1Sel = Rs1Ra;
		RwSel = RwRd;
		WdSel = WdAlu;
		StatusWe = 1'b0;
		IntClear = 1'b0;
		IntEnable = 1'b0;
		IntDisable = 1'b0;
		case (State)
			fetch:
				case (SubCycle)
					cycle0: begin
						ALE = 1'b1;	// PC out as address
						PcEn = 1'b1;
					end
					cycle1: begin
						nME = 1'b0;
						MemEn = 1'b1;
						PcEn = 1'b1;
					end
					cycle2: begin
						nME = 1'b0;
						nOE = 1'b0;
						MemEn = 1'b1;
						Enb = 1'b1;
						IrWe = 1'b1;
					end
					cycle3: begin
						nOE = 1'b0;
						MemEn = 1'b1;
						Enb = 1'b1;
					end
					default: ;
				endcase
			execute:
				case (SubCycle)
					cycle4:
						case (opcode)
							ADD, ADDI, ADDIB, ADC, ADCI, SUB, SUBI, SUBIB, SUC, SUCI,
							CMP, CMPI, AND, OR, XOR, NOT, NAND, NOR, LSL, LSR, ASR, NEG: begin
								PcEn = 1'b1;
								PcWe = 1'b1;
								StatusWe = 1'b1;
								RegWe = (opcode != CMP) && (opcode != CMPI);	// Compare sets flags only
								case (opcode)
									ADD, SUB, CMP, AND, OR, XOR, NAND, NOR: Op2Sel = Op2Rd2;
									ADDI, SUBI, CMPI, LSL, LSR, ASR: ImmSel = ImmShort;
									ADDIB, SUBIB: Rs1Sel = Rs1Rd;
									default: ;
								endcase
							end
							LUI, LLI: begin
								AluEn = 1'b1;
								Rs1Sel = Rs1Rd;
								RegWe = 1'b1;
								PcWe = 1'b1;
							end
							LDW, STW: begin
								// Address add before the bus cycle
								AluEn = 1'b1;
								AluWe = 1'b1;
								ImmSel = ImmShort;
							end
							BRANCH:
								case (Instr.branch.cond)
									JMP: begin
										ImmSel = ImmShort;
										PcSel = PcAluOut;
										PcWe = 1'b1;
									end
									RET: begin
										LrEn = 1'b1;
										PcSel = PcSysbus;
										PcWe = 1'b1;
									end
									default: begin
										PcWe = 1'b1;
										Op1Sel = Op1Pc;	// PC relative target
										AluEn = 1'b1;
										if (BranchTaken) begin
											PcSel = PcAluOut;
											if (Instr.branch.cond == BWL) begin
												LrWe = 1'b1;
												LrSel = LrPc;
											end
										end
									end
								endcase
							INTERRUPT: begin
								PcEn = 1'b1;
								PcWe = 1'b1;
								IntEnable = (Instr.system.op == EI);
								IntDisable = (Instr.system.op == DI);
							end
							default: ;
						endcase
					cycle0: begin
						ALE = 1'b1;
						ImmSel = ImmShort;
						AluEn = 1'b1;
					end
					cycle1: begin
						nME = 1'b0;
						Op2Sel = Op2zero;
						Rs1Sel = Rs1Rd;
						AluWe = 1'b1;	// Store data passes through
						AluEn = 1'b1;
						MemEn = (opcode == LDW);
					end
					cycle2: begin
						PcWe = 1'b1;
						nME = 1'b0;
						if (opcode == LDW) begin
							nOE = 1'b0;
							MemEn = 1'b1;
							Enb = 1'b1;
							WdSel = WdSys;
							RegWe = 1'b1;
						end else begin
							AluEn = 1'b1;
							Op2Sel = Op2zero;
						end
					end
					default: begin
						if (opcode == LDW) begin
							nOE = 1'b0;
							MemEn = 1'b1;
							Enb = 1'b1;
						end else begin
							nWE = 1'b0;	// Write strobe
							AluEn = 1'b1;
							Op2Sel = Op2zero;
						end
					end
				endcase
			interrupt:
				case (SubCycle)
					cycle0: begin
						Rs1Sel = Seven;	// SP decrement
						RwSel = RwSeven;
						AluOr = subOR;
						Op2Sel = Op2zero;
						AluEn = 1'b1;
						AluWe = 1'b1;
						RegWe = 1'b1;
					end
					cycle1: begin
						ALE = 1'b1;
						Rs1Sel = Seven;
						AluOr = subOR;
						Op2Sel = Op2zero;
						AluEn = 1'b1;
					end
					cycle2: begin
						nME = 1'b0;
						Op2Sel = Op2zero;
						AluEn = 1'b1;
					end
					cycle3: begin
						nME = 1'b0;
						nWE = 1'b0;	// Push return PC
						PcEn = 1'b1;
					end
					default: begin
						PcEn = 1'b1;
						PcSel = PcInt;
						PcWe = 1'b1;
						IntClear = 1'b1;
					end
				endcase
			default: ;
		endcase
	end

endmodule

// File: rtl/controlPkg.sv
// Flag positions, field widths, state and select enums, instruction byte union
package controlPkg;

	localparam int flagZ = 0;
	localparam int flagC = 1;
	localparam int flagV = 2;
	localparam int flagN = 3;
	localparam int flagWidth = 4;
	localparam int opcodeWidth = 5;
	localparam int condWidth = 3;

	typedef enum logic [1:0] {fetch, execute, interrupt} majorState_t;

	typedef enum logic [2:0] {cycle0, cycle1, cycle2, cycle3, cycle4} subCycle_t;

	typedef enum logic [opcodeWidth-1:0] {
		ADD, ADDI, ADDIB, ADC, ADCI, SUB, SUBI, SUBIB, SUC, SUCI,
		CMP, CMPI, AND, OR, XOR, NOT, NAND, NOR, LSL, LSR, ASR, NEG,
		LUI, LLI, LDW, STW, PUSH, POP, BRANCH, INTERRUPT
	} opcode_t;

	typedef enum logic [condWidth-1:0] {BR, JMP, RET, BWL, BNE, BE, BLT, BGE} branch_t;

	// Low field under INTERRUPT
	typedef enum logic [condWidth-1:0] {
		SysNop = 3'd0,
		EI = 3'd1,
		DI = 3'd2
	} sysOp_t;

	typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus, PcInt} pcSel_t;
	typedef enum logic {ImmLong, ImmShort} immSel_t;
	typedef enum logic {Op1Rd1, Op1Pc} op1Sel_t;
	typedef enum logic [1:0] {Op2Imm, Op2Rd2, Op2zero} op2Sel_t;
	typedef enum logic [1:0] {Rs1Ra, Rs1Rd, Seven} rs1Sel_t;
	typedef enum logic {RwRd, RwSeven} rwSel_t;
	typedef enum logic {WdAlu, WdSys} wdSel_t;
	typedef enum logic {LrSys, LrPc} lrSel_t;
	typedef enum logic [1:0] {
		nOR = 2'd0,
		subOR = 2'd2	// Force a decrement on the ALU
	} aluOr_t;

	typedef struct packed {
		opcode_t opcode;
		branch_t cond;
	} branchView_t;

	typedef struct packed {
		opcode_t opcode;
		sysOp_t op;
	} systemView_t;

	typedef union packed {
		branchView_t branch;
		systemView_t system;
	} instrByte_t;

endpackage

// File: rtl/cpuControl.sv
// Processor control unit top level
`timescale 1ns/10ps

module cpuControl import controlPkg::*; (
	input logic Clock,
	input logic nReset,
	input instrByte_t Instr,
	input logic [flagWidth-1:0] Flags,
	input logic nIRQ,
	input logic nWait,
	output logic ALE,
	output logic AluEn,
	output logic AluWe,
	output aluOr_t AluOr,
	output logic CFlag,
	output logic Enb,
	output immSel_t ImmSel,
	output logic IrWe,
	output logic LrEn,
	output lrSel_t LrSel,
	output logic LrWe,
	output logic MemEn,
	output logic nME,
	output logic nOE,
	output logic nWE,
	output op1Sel_t Op1Sel,
	output op2Sel_t Op2Sel,
	output logic PcEn,
	output pcSel_t PcSel,
	output logic PcWe,
	output logic RegWe,
	output rs1Sel_t Rs1Sel,
	output rwSel_t RwSel,
	output wdSel_t WdSel
);

	majorState_t state;
	subCycle_t subCycle;
	logic intReq;
	logic intClear;
	logic intEnable;
	logic intDisable;
	logic statusWe;
	logic branchTaken;

	irqSync irq (
		.Clock(Clock),
		.nReset(nReset),
		.nIRQ(nIRQ),
		.IntClear(intClear),
		.IntEnable(intEnable),
		.IntDisable(intDisable),
		.IntReq(intReq)
	);

	flagCondition flags (
		.Clock(Clock),
		.nReset(nReset),
		.Flags(Flags),
		.StatusWe(statusWe),
		.Cond(Instr.branch.cond),
		.BranchTaken(branchTaken),
		.CFlag(CFlag)
	);

	cycleSequencer sequencer (
		.Clock(Clock),
		.nReset(nReset),
		.Opcode(Instr.branch.opcode),
		.nWait(nWait),
		.IntReq(intReq),
		.State(state),
		.SubCycle(subCycle)
	);

	controlDecode decode (
		.State(state),
		.SubCycle(subCycle),
		.Instr(Instr),
		.BranchTaken(branchTaken),
		.ALE(ALE),
		.AluEn(AluEn),
		.AluWe(AluWe),
		.AluOr(AluOr),
		.Enb(Enb),
		.ImmSel(ImmSel),
		.IrWe(IrWe),
		.LrEn(LrEn),
		.LrSel(LrSel),
		.LrWe(LrWe),
		.MemEn(MemEn),
		.nME(nME),
		.nOE(nOE),
		.nWE(nWE),
		.Op1Sel(Op1Sel),
		.Op2Sel(Op2Sel),
		.PcEn(PcEn),
		.PcSel(PcSel),
		.PcWe(PcWe),
		.RegWe(RegWe),
		.Rs1Sel(Rs1Sel),
		.RwSel(RwSel),
		.WdSel(WdSel),
		.StatusWe(statusWe),
		.IntClear(intClear),
		.IntEnable(intEnable),
		.IntDisable(intDisable)
	);

endmodule

// File: rtl/cycleSequencer.sv
// Major state and subcycle sequencer with memory wait states
`timescale 1ns/10ps

module cycleSequencer import controlPkg::*; (
	input logic Clock,
	input logic nReset,
	input opcode_t Opcode,
	input logic nWait,
	input logic IntReq,
	output majorState_t State,
	output subCycle_t SubCycle
);

	majorState_t nextState;
	subCycle_t nextSub;
	logic memOp;

	assign memOp = (Opcode == LDW) || (Opcode == STW);

	always_comb begin
		nextState = State;
		nextSub = SubCycle;
		case (State)
			fetch:
				case (SubCycle)
					cycle0: nextSub = cycle1;
					cycle1: nextSub = cycle2;
					cycle2: if (nWait) nextSub = cycle3;	// Instruction read
					cycle3: begin
						nextState = execute;
						nextSub = cycle4;
					end
					default: nextSub = cycle0;
				endcase
			execute:
				case (SubCycle)
					cycle0: nextSub = cycle1;
					cycle1: nextSub = cycle2;
					cycle2: if (nWait) nextSub = cycle3;	// Data transfer
					default: begin
						// cycle4 ends single-cycle ops, cycle3 ends LDW/STW
						nextSub = cycle0;
						if (SubCycle == cycle4 && memOp)
							nextState = execute;
						else if (IntReq)
							nextState = interrupt;
						else
							nextState = fetch;
					end
				endcase
			interrupt:
				case (SubCycle)
					cycle0: nextSub = cycle1;
					cycle1: nextSub = cycle2;
					cycle2: nextSub = cycle3;
					cycle3: nextSub = cycle4;
					default: begin
						nextState = fetch;
						nextSub = cycle0;
					end
				endcase
			default: begin
				nextState = fetch;
				nextSub = cycle0;
			end
		endcase
	end

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			State <= fetch;
			SubCycle <= cycle0;
		end else begin
			State <= nextState;
			SubCycle <= nextSub;
		end
	end

endmodule

// File: rtl/flagCondition.sv
// Status flags register, carry output and branch condition test
`timescale 1ns/10ps

module flagCondition import controlPkg::*; (
	input logic Clock,
	input logic nReset,
	input logic [flagWidth-1:0] Flags,
	input logic StatusWe,
	input branch_t Cond,
	output logic BranchTaken,
	output logic CFlag
);

	logic [flagWidth-1:0] statusReg;

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset)
			statusReg <= '0;
		else if (StatusWe)
			statusReg <= Flags;
	end

	assign CFlag = statusReg[flagC];

	always_comb begin
		case (Cond)
			BR, BWL: BranchTaken = 1'b1;
			BNE: BranchTaken = ~statusReg[flagZ];
			BE: BranchTaken = statusReg[flagZ];
			BLT: BranchTaken = statusReg[flagN] ^ statusReg[flagV];	// Signed less than
			BGE: BranchTaken = ~(statusReg[flagN] ^ statusReg[flagV]);
			default: BranchTaken = 1'b0;	// JMP and RET handled by decoder
		endcase
	end

endmodule

// File: rtl/irqSync.sv
// Interrupt request synchronizer, falling edge detect, pending latch and enable bit
`timescale 1ns/10ps

module irqSync (
	input logic Clock,
	input logic nReset,
	input logic nIRQ,
	input logic IntClear,
	input logic IntEnable,
	input logic IntDisable,
	output logic IntReq
);

	logic irqMeta;
	logic irqSynced;
	logic irqEnabled;
	logic irqFall;

	assign irqFall = irqMeta & ~irqSynced;	// nIRQ just went low

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			irqMeta <= 1'b0;
			irqSynced <= 1'b0;
			irqEnabled <= 1'b0;
			IntReq <= 1'b0;
		end else begin
			irqMeta <= ~nIRQ;
			irqSynced <= irqMeta;
			// Held until entry sequence is done
			IntReq <= (irqFall & irqEnabled) | (IntReq & ~IntClear);
			if (IntEnable)
				irqEnabled <= 1'b1;
			else if (IntDisable)
				irqEnabled <= 1'b0;
		end
	end

endmodule

// File: testbench/cpuControlTb.sv
// Control unit testbench with clock, reset, random program, reference model, compare and watchdog
`timescale 1ns/10ps

module cpuControlTb import controlPkg::*; ();

	localparam int resetCycles = 10;
	localparam int directedCount = 4;
	localparam int randomCount = 300;
	localparam int programSize = directedCount + randomCount;
	localparam int maxWait = 3;
	localparam int cycleBudget = 14 + 2 * maxWait;	// Fetch, LDW/STW, entry, waits

	logic Clock;
	logic nReset;
	instrByte_t Instr;
	logic [flagWidth-1:0] Flags;
	logic nIRQ;
	logic nWait;
	logic ALE;
	logic AluEn;
	logic AluWe;
	aluOr_t AluOr;
	logic CFlag;
	logic Enb;
	immSel_t ImmSel;
	logic IrWe;
	logic LrEn;
	lrSel_t LrSel;
	logic LrWe;
	logic MemEn;
	logic nME;
	logic nOE;
	logic nWE;
	op1Sel_t Op1Sel;
	op2Sel_t Op2Sel;
	logic PcEn;
	pcSel_t PcSel;
	logic PcWe;
	logic RegWe;
	rs1Sel_t Rs1Sel;
	rwSel_t RwSel;
	wdSel_t WdSel;

	logic [31:0] lfsrState = 32'hb12b_b5ce;
	instrByte_t programInstr[$];
	logic programIrq[$];
	int pcIntCount = 0;

	// Tracked sequencer, flags and interrupt logic
	majorState_t modelState;
	subCycle_t modelSub;
	logic [flagWidth-1:0] modelFlags;
	logic modelEnabled;
	logic modelMeta;
	logic modelSynced;
	logic modelPending;

	cpuControl u_cpuControl (.*);

	initial begin
		Clock = 1'b0;
		forever #4 Clock = ~Clock;
	end

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'h8020_0003;
		return n;
	endfunction

	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrStep(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
		return value;
	endfunction

	function automatic instrByte_t makeInstr(input opcode_t op, input logic [2:0] low);
		instrByte_t b;
		b = {op, low};
		return b;
	endfunction

	function automatic logic isAluOp(input opcode_t op);
		return op inside {ADD, ADDI, ADDIB, ADC, ADCI, SUB, SUBI, SUBIB, SUC, SUCI,
			CMP, CMPI, AND, OR, XOR, NOT, NAND, NOR, LSL, LSR, ASR, NEG};
	endfunction

	function automatic logic branchTaken(input branch_t c, input logic [flagWidth-1:0] fl);
		case (c)
			BR, BWL: return 1'b1;
			BNE: return !fl[flagZ];
			BE: return fl[flagZ];
			BLT: return fl[flagN] != fl[flagV];
			BGE: return fl[flagN] == fl[flagV];
			default: return 1'b0;
		endcase
	endfunction

	// Packed as ALE, IrWe, nME, nWE, RegWe, PcWe, PcSel, LrWe, LrSel, WdSel, CFlag
	function automatic logic [11:0] expectedStrobes(input majorState_t st, input subCycle_t sub,
		input instrByte_t ins, input logic [flagWidth-1:0] fl);
		logic ale;
		logic irWe;
		logic nMe;
		logic nWe;
		logic regWe;
		logic pcWe;
		logic lrWe;
		pcSel_t pcSel;
		lrSel_t lrSel;
		wdSel_t wdSel;
		opcode_t op;
		ale = 1'b0;
		irWe = 1'b0;
		nMe = 1'b1;
		nWe = 1'b1;
		regWe = 1'b0;
		pcWe = 1'b0;
		lrWe = 1'b0;
		pcSel = Pc1;
		lrSel = LrSys;
		wdSel = WdAlu;
		op = ins.branch.opcode;
		case (st)
			fetch: begin
				ale = (sub == cycle0);
				nMe = !(sub == cycle1 || sub == cycle2);
				irWe = (sub == cycle2);
			end
			execute:
				case (sub)
					cycle4: begin
						pcWe = isAluOp(op) || op == LUI || op == LLI || op == INTERRUPT;
						regWe = (isAluOp(op) && op != CMP && op != CMPI) || op == LUI || op == LLI;
						if (op == BRANCH) begin
							pcWe = 1'b1;
							if (ins.branch.cond == JMP)
								pcSel = PcAluOut;
							else if (ins.branch.cond == RET)
								pcSel = PcSysbus;
							else if (branchTaken(ins.branch.cond, fl)) begin
								pcSel = PcAluOut;
								lrWe = (ins.branch.cond == BWL);	// Link on call
								if (lrWe)
									lrSel = LrPc;
							end
						end
					end
					cycle0: ale = 1'b1;
					cycle1: nMe = 1'b0;
					cycle2: begin
						nMe = 1'b0;
						pcWe = 1'b1;
						regWe = (op == LDW);
						if (op == LDW)
							wdSel = WdSys;	// Load data from the bus
					end
					default: nWe = (op != STW);
				endcase
			default:
				case (sub)
					cycle0: regWe = 1'b1;	// SP decrement
					cycle1: ale = 1'b1;
					cycle2: nMe = 1'b0;
					cycle3: begin
						nMe = 1'b0;
						nWe = 1'b0;
					end
					default: begin
						pcSel = PcInt;
						pcWe = 1'b1;
					end
				endcase
		endcase
		return {ale, irWe, nMe, nWe, regWe, pcWe, pcSel, lrWe, lrSel, wdSel, fl[flagC]};
	endfunction

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("[ERROR] %0d ns: %s, expected %h, got %h", $time, what, expected, actual);
			$display("sim failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic buildProgram();
		logic [31:0] r;
		logic [31:0] low;
		programInstr.push_back(makeInstr(INTERRUPT, EI));
		programIrq.push_back(1'b0);
		programInstr.push_back(makeInstr(ADD, 3'd0));
		programIrq.push_back(1'b1);
		programInstr.push_back(makeInstr(INTERRUPT, DI));
		programIrq.push_back(1'b0);
		programInstr.push_back(makeInstr(ADD, 3'd0));
		programIrq.push_back(1'b1);
		repeat (randomCount) begin
			do
				r = randomBits(opcodeWidth);
			while (r[4:0] == PUSH || r[4:0] == POP || r[4:0] > INTERRUPT);
			low = randomBits(condWidth);
			programInstr.push_back(makeInstr(opcode_t'(r[4:0]), low[2:0]));
			low = randomBits(3);
			programIrq.push_back(low[2:0] == 3'd0);	// About one in eight
		end
	endtask

	always @(posedge Clock or negedge nReset) begin : tracker
		logic fall;
		opcode_t op;
		majorState_t nextState;
		subCycle_t nextSub;
		if (!nReset) begin
			modelState = fetch;
			modelSub = cycle0;
			modelFlags = '0;
			modelEnabled = 1'b0;
			modelMeta = 1'b0;
			modelSynced = 1'b0;
			modelPending = 1'b0;
		end else begin
			op = Instr.branch.opcode;
			fall = modelMeta && !modelSynced;
			nextState = modelState;
			nextSub = modelSub;
			case (modelState)
				fetch:
					if (modelSub == cycle3) begin
						nextState = execute;
						nextSub = cycle4;
					end else if (modelSub != cycle2 || nWait)
						nextSub = subCycle_t'(modelSub + 3'd1);
				execute:
					if (modelSub == cycle4 && (op == LDW || op == STW))
						nextSub = cycle0;
					else if (modelSub == cycle4 || modelSub == cycle3) begin
						nextState = modelPending ? interrupt : fetch;
						nextSub = cycle0;
					end else if (modelSub != cycle2 || nWait)
						nextSub = subCycle_t'(modelSub + 3'd1);
				default:
					if (modelSub == cycle4) begin
						nextState = fetch;
						nextSub = cycle0;
					end else
						nextSub = subCycle_t'(modelSub + 3'd1);
			endcase
			modelPending = (fall && modelEnabled) ||
				(modelPending && !(modelState == interrupt && modelSub == cycle4));
			modelSynced = modelMeta;
			modelMeta = !nIRQ;
			if (modelState == execute && modelSub == cycle4) begin
				if (isAluOp(op))
					modelFlags = Flags;
				if (op == INTERRUPT && Instr.system.op == EI)
					modelEnabled = 1'b1;
				else if (op == INTERRUPT && Instr.system.op == DI)
					modelEnabled = 1'b0;
			end
			modelState = nextState;
			modelSub = nextSub;
		end
	end

	always @(negedge Clock) begin : compare
		logic [11:0] actual;
		logic [11:0] expected;
		if (nReset) begin
			actual = {ALE, IrWe, nME, nWE, RegWe, PcWe, PcSel, LrWe, LrSel, WdSel, CFlag};
			expected = expectedStrobes(modelState, modelSub, Instr, modelFlags);
			checkValue(32'(actual), 32'(expected), $sformatf("strobes in %s %s, instruction %h",
				modelState.name(), modelSub.name(), Instr));
			if (modelState == fetch && modelSub == cycle0)
				checkValue(32'(nOE), 32'd1, "nOE in fetch cycle0");
			checkValue(32'(u_cpuControl.checks.errorCount), 32'd0,
				"assertion failures in the bound checker");
			if (PcSel == PcInt)
				pcIntCount++;
		end
	end

	initial begin : stimulus
		int index;
		int waitRun;
		logic [31:0] r;
		logic done;
		index = 0;
		waitRun = 0;
		done = 1'b0;
		nReset = 1'b0;
		Instr = '0;
		Flags = '0;
		nIRQ = 1'b1;
		nWait = 1'b1;
		buildProgram();
		repeat (resetCycles) @(posedge Clock);
		#1;
		nReset = 1'b1;
		while (!done) begin
			r = randomBits(flagWidth);
			Flags = r[flagWidth-1:0];
			nWait = 1'b1;
			if (modelState == execute)
				nIRQ = 1'b1;	// Request released once decoded
			if (modelState == fetch && modelSub == cycle0) begin
				if (index == directedCount)
					checkValue(32'(pcIntCount), 32'd1, "interrupt entries after EI and DI");
				if (index == programSize)
					done = 1'b1;
				else begin
					Instr = programInstr[index];
					nIRQ = !programIrq[index];
					index++;
				end
			end
			if (modelState != interrupt && modelSub == cycle2) begin
				r = randomBits(2);
				if (waitRun < maxWait && r[1:0] == 2'b00) begin
					nWait = 1'b0;
					waitRun++;
				end else
					waitRun = 0;
			end
			@(posedge Clock);
			#1;
		end
		repeat (2) @(posedge Clock);
		if (u_cpuControl.checks.errorCount == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("sim failed");
			$fatal(1, "assertion failures in the bound checker");
		end
	end

	initial begin : watchdog
		repeat (resetCycles + programSize * cycleBudget + 20) @(posedge Clock);
		$display("Timeout: the program did not finish in the expected number of cycles");
		$display("sim failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: testbench/cpuControl_checker.sv
// Bound assertions on strobe protocol and reset state of the control unit
`timescale 1ns/10ps

module cpuControl_checker import controlPkg::*; (
	input logic Clock,
	input logic nReset,
	input logic nWait,
	input logic ALE,
	input logic nME,
	input logic IrWe,
	input logic PcWe,
	input pcSel_t PcSel,
	input logic AluEn,
	input logic AluWe,
	input logic Enb,
	input logic LrEn,
	input logic LrWe,
	input logic MemEn,
	input logic RegWe
);

	int errorCount = 0;

	// Address phase and memory select are exclusive
	aleMemExclusive: assert property (@(posedge Clock) !(ALE && !nME))
		else begin
			$error("ALE and nME active in the same cycle");
			errorCount++;
		end

	irWeSingle: assert property (@(posedge Clock) disable iff (!nReset)
		IrWe && nWait |=> !IrWe)
		else begin
			$error("IrWe held past the end of the instruction read");
			errorCount++;
		end

	pcIntWrite: assert property (@(posedge Clock) disable iff (!nReset)
		PcSel == PcInt |-> PcWe)
		else begin
			$error("PcSel is PcInt without PcWe");
			errorCount++;
		end

	resetQuiet: assert property (@(posedge Clock)
		!nReset |-> !(AluEn || AluWe || Enb || LrEn || LrWe || MemEn || RegWe || PcWe || IrWe))
		else begin
			$error("enable or write strobe active during reset");
			errorCount++;
		end

endmodule

bind cpuControl cpuControl_checker checks (
	.Clock(Clock),
	.nReset(nReset),
	.nWait(nWait),
	.ALE(ALE),
	.nME(nME),
	.IrWe(IrWe),
	.PcWe(PcWe),
	.PcSel(PcSel),
	.AluEn(AluEn),
	.AluWe(AluWe),
	.Enb(Enb),
	.LrEn(LrEn),
	.LrWe(LrWe),
	.MemEn(MemEn),
	.RegWe(RegWe)
);
